// File: verilog/equalizer_defs.svh
`ifndef EQUALIZER_DEFS_SVH
`define EQUALIZER_DEFS_SVH

// symbol geometry
`define EQ_NUM_SC   64
`define EQ_ADDR_W   6
`define EQ_IQ_W     16
`define EQ_NUM_DATA 48
`define EQ_POL_LEN  127

// index 0 is DC, 1..26 are the positive and 38..63 the negative subcarriers
// pilots sit at 7, 21, 43 and 57
`define EQ_PILOT_MASK 64'h0200_0800_0020_0080
`define EQ_DATA_MASK  64'hfdff_f7c0_07df_ff7e

// a one negates the second LTS value at that index
`define EQ_LTS_REF \
    64'b0000101001100000010100110000000000000000010101100111110101001100

// pilot polarity, consumed from bit 0 one bit per data symbol
`define EQ_POLARITY { \
    63'b11111110_00111011_00010100_10111110_10101000_01011011_11001110_0101011, \
    64'b0_01100000_11011010_11101000_11001000_10000001_00100110_10011110_1110000}

`endif

// File: verilog/equalizer_pkg.sv
`include "equalizer_defs.svh"

package equalizer_pkg;

    // one complex sample or estimate
    typedef struct packed {
        logic signed [`EQ_IQ_W-1:0] i;
        logic signed [`EQ_IQ_W-1:0] q;
    } iq_t;

    // write port of the estimate memory
    typedef struct packed {
        logic                  en;
        logic [`EQ_ADDR_W-1:0] addr;
        iq_t                   data;
    } ram_wr_t;

    // sample times conjugate estimate, plus |estimate|^2 for the divider
    typedef struct packed {
        logic signed [31:0] prod_i;
        logic signed [31:0] prod_q;
        logic [31:0]        mag_sq;
    } eq_out_t;

    // phase estimator request
    typedef struct packed {
        logic signed [31:0] sum_i;
        logic signed [31:0] sum_q;
    } pilot_sum_t;

    typedef enum logic [1:0] {
        EST_FIRST,
        EST_SECOND,
        EST_DONE
    } est_state_t;

endpackage

// File: verilog/lts_estimator.sv
`timescale 1ns/10ps
`include "equalizer_defs.svh"

module lts_estimator (
    input  logic                     clock,
    input  logic                     reset,
    input  logic                     enable_i,
    input  equalizer_pkg::iq_t       sample_i,
    input  logic                     sample_stb_i,
    input  equalizer_pkg::iq_t       rd_data_i,
    output equalizer_pkg::ram_wr_t   wr_o,
    output logic [`EQ_ADDR_W-1:0]    rd_addr_o,
    output logic                     done_o
);

    equalizer_pkg::est_state_t state;
    logic [`EQ_ADDR_W-1:0] in_addr;
    logic [`EQ_NUM_SC-1:0] lts_ref;
    logic lts_full;
    logic take;
    logic wr_last;
    // second LTS sample waiting for the stored first one
    logic s1_valid;
    logic s1_sign;
    logic [`EQ_ADDR_W-1:0] s1_addr;
    equalizer_pkg::iq_t s1_sample;
    logic signed [`EQ_IQ_W:0] sec_i;
    logic signed [`EQ_IQ_W:0] sec_q;
    logic signed [`EQ_IQ_W:0] sum_i;
    logic signed [`EQ_IQ_W:0] sum_q;

    // nothing more is taken once all 128 training samples are in
    assign take = enable_i && sample_stb_i && !lts_full;
    // keep the pending address on the RAM so its read data survives a stall
    assign rd_addr_o = (!enable_i && s1_valid) ? s1_addr : in_addr;
    assign done_o = (state == equalizer_pkg::EST_DONE);

    always_comb begin
        sec_i = 17'(s1_sample.i);
        sec_q = 17'(s1_sample.q);
        if (s1_sign) begin
            sec_i = -sec_i;
            sec_q = -sec_q;
        end
        sum_i = 17'(rd_data_i.i) + sec_i;
        sum_q = 17'(rd_data_i.q) + sec_q;
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            state <= equalizer_pkg::EST_FIRST;
            in_addr <= '0;
            lts_ref <= `EQ_LTS_REF;
            lts_full <= 1'b0;
            s1_valid <= 1'b0;
            wr_last <= 1'b0;
            wr_o.en <= 1'b0;
        end else if (enable_i) begin
            s1_valid <= 1'b0;
            wr_last <= 1'b0;
            wr_o.en <= 1'b0;
            if (take) begin
                in_addr <= in_addr + 1'b1;
                if (state == equalizer_pkg::EST_FIRST) begin
                    // first LTS goes in untouched
                    wr_o.en <= 1'b1;
                    wr_o.addr <= in_addr;
                    wr_o.data <= sample_i;
                    if (in_addr == '1) begin
                        state <= equalizer_pkg::EST_SECOND;
                    end
                end else begin
                    s1_valid <= 1'b1;
                    s1_addr <= in_addr;
                    s1_sample <= sample_i;
                    s1_sign <= lts_ref[0];
                    lts_ref <= {lts_ref[0], lts_ref[`EQ_NUM_SC-1:1]};
                    lts_full <= (in_addr == '1);
                end
            end
            // mean of both symbols, halved by dropping the lsb
            if (s1_valid) begin
                wr_o.en <= 1'b1;
                wr_o.addr <= s1_addr;
                wr_o.data.i <= sum_i[`EQ_IQ_W:1];
                wr_o.data.q <= sum_q[`EQ_IQ_W:1];
                wr_last <= (s1_addr == '1);
            end
            if (wr_last) begin
                state <= equalizer_pkg::EST_DONE;
            end
        end
    end

    // the pipeline must have drained before the estimate is declared ready
    no_write_when_done: assert property (
        @(posedge clock) disable iff (reset)
        (state == equalizer_pkg::EST_DONE) |-> !wr_o.en);

endmodule

// File: verilog/channel_ram.sv
`timescale 1ns/10ps
`include "equalizer_defs.svh"

module channel_ram (
    input  logic                     clock,
    input  equalizer_pkg::ram_wr_t   wr_i,
    input  logic [`EQ_ADDR_W-1:0]    rd_a_addr_i,
    input  logic [`EQ_ADDR_W-1:0]    rd_b_addr_i,
    output equalizer_pkg::iq_t       rd_a_data_o,
    output equalizer_pkg::iq_t       rd_b_data_o
);

    // one entry per subcarrier
    equalizer_pkg::iq_t mem [`EQ_NUM_SC];

    always_ff @(posedge clock) begin
        if (wr_i.en) begin
            mem[wr_i.addr] <= wr_i.data;
        end
    end

    // port a serves the estimator
    // a read colliding with a write returns the old entry
    always_ff @(posedge clock) begin
        rd_a_data_o <= mem[rd_a_addr_i];
    end

    // port b serves the symbol equalizer
    always_ff @(posedge clock) begin
        rd_b_data_o <= mem[rd_b_addr_i];
    end

    // the estimator must never hand over an unsettled address
    wr_addr_known: assert property (
        @(posedge clock) wr_i.en |-> !$isunknown(wr_i.addr));

endmodule

// File: verilog/symbol_equalizer.sv
`timescale 1ns/10ps
`include "equalizer_defs.svh"

module symbol_equalizer (
    input  logic                        clock,
    input  logic                        reset,
    input  logic                        enable_i,
    input  logic                        est_done_i,
    input  equalizer_pkg::iq_t          sample_i,
    input  logic                        sample_stb_i,
    input  equalizer_pkg::iq_t          rd_data_i,
    output logic [`EQ_ADDR_W-1:0]       rd_addr_o,
    output equalizer_pkg::eq_out_t      eq_out_o,
    output logic                        eq_out_stb_o,
    output equalizer_pkg::pilot_sum_t   pilot_sum_o,
    output logic                        pilot_sum_stb_o
);

    localparam logic [`EQ_POL_LEN-1:0] pol_seq = `EQ_POLARITY;

    logic take;
    logic [`EQ_ADDR_W-1:0] sc_idx;
    logic [`EQ_NUM_SC-1:0] data_mask;
    logic [`EQ_NUM_SC-1:0] pilot_mask;
    logic [`EQ_POL_LEN-1:0] polarity;
    logic [3:0] cur_pol;
    logic [1:0] pilot_cnt;
    // stage one
    logic s1_valid;
    logic s1_data;
    logic s1_pilot;
    logic s1_pol;
    logic [1:0] s1_pcnt;
    logic [`EQ_ADDR_W-1:0] s1_addr;
    equalizer_pkg::iq_t s1_sample;
    // stage two
    logic eq_stb_q;
    logic pilot_stb_q;
    logic signed [31:0] smp_i;
    logic signed [31:0] smp_q;
    logic signed [31:0] est_i;
    logic signed [31:0] est_q;
    logic signed [31:0] prod_i;
    logic signed [31:0] prod_q;
    logic [31:0] mag_sq;
    logic signed [31:0] pil_i;
    logic signed [31:0] pil_q;
    logic signed [31:0] acc_i;
    logic signed [31:0] acc_q;
    logic signed [31:0] sum_i;
    logic signed [31:0] sum_q;

    // pilot polarity for indices 7, 21, 43, 57 from bit 0 upward
    function automatic logic [3:0] pilot_pattern(input logic p);
        pilot_pattern = {p, p, ~p, p};
    endfunction

    assign take = enable_i && est_done_i && sample_stb_i;
    assign rd_addr_o = (!enable_i && s1_valid) ? s1_addr : sc_idx;
    assign eq_out_stb_o = eq_stb_q && enable_i;
    assign pilot_sum_stb_o = pilot_stb_q && enable_i;

    always_comb begin
        smp_i = 32'(s1_sample.i);
        smp_q = 32'(s1_sample.q);
        est_i = 32'(rd_data_i.i);
        est_q = 32'(rd_data_i.q);
        // sample * conj(estimate)
        prod_i = smp_i * est_i + smp_q * est_q;
        prod_q = smp_q * est_i - smp_i * est_q;
        mag_sq = est_i * est_i + est_q * est_q;
        // conj(pilot) * estimate equals conj(prod), negated for polarity 1
        pil_i = s1_pol ? -prod_i : prod_i;
        pil_q = s1_pol ? prod_q : -prod_q;
        sum_i = (s1_pcnt == 2'd0) ? pil_i : acc_i + pil_i;
        sum_q = (s1_pcnt == 2'd0) ? pil_q : acc_q + pil_q;
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            sc_idx <= '0;
            data_mask <= `EQ_DATA_MASK;
            pilot_mask <= `EQ_PILOT_MASK;
            polarity <= pol_seq;
            cur_pol <= pilot_pattern(pol_seq[0]);
            pilot_cnt <= '0;
            s1_valid <= 1'b0;
            eq_stb_q <= 1'b0;
            pilot_stb_q <= 1'b0;
        end else if (enable_i) begin
            s1_valid <= take;
            if (take) begin
                s1_addr <= sc_idx;
                s1_sample <= sample_i;
                s1_data <= data_mask[0];
                s1_pilot <= pilot_mask[0];
                s1_pol <= cur_pol[0];
                s1_pcnt <= pilot_cnt;
                sc_idx <= sc_idx + 1'b1;
                data_mask <= {data_mask[0], data_mask[`EQ_NUM_SC-1:1]};
                pilot_mask <= {pilot_mask[0], pilot_mask[`EQ_NUM_SC-1:1]};
                if (pilot_mask[0]) begin
                    pilot_cnt <= pilot_cnt + 1'b1;
                    cur_pol <= {cur_pol[0], cur_pol[3:1]};
                end
                // next symbol takes the next polarity bit
                if (sc_idx == '1) begin
                    polarity <= {polarity[0], polarity[`EQ_POL_LEN-1:1]};
                    cur_pol <= pilot_pattern(polarity[1]);
                end
            end
            eq_stb_q <= s1_valid && s1_data;
            pilot_stb_q <= s1_valid && s1_pilot && (s1_pcnt == 2'd3);
            if (s1_valid && s1_data) begin
                eq_out_o.prod_i <= prod_i;
                eq_out_o.prod_q <= prod_q;
                eq_out_o.mag_sq <= mag_sq;
            end
            if (s1_valid && s1_pilot) begin
                acc_i <= sum_i;
                acc_q <= sum_q;
                if (s1_pcnt == 2'd3) begin
                    pilot_sum_o.sum_i <= sum_i;
                    pilot_sum_o.sum_q <= sum_q;
                end
            end
        end
    end

    // data and pilot masks never overlap, so the two outputs never coincide
    one_output_at_a_time: assert property (
        @(posedge clock) disable iff (reset)
        !(eq_out_stb_o && pilot_sum_stb_o));

endmodule

// File: verilog/equalizer_top.sv
`timescale 1ns/10ps
`include "equalizer_defs.svh"

module equalizer_top (
    input  logic                        clock,
    input  logic                        reset,
    input  logic                        enable_i,
    input  equalizer_pkg::iq_t          sample_i,
    input  logic                        sample_stb_i,
    output equalizer_pkg::eq_out_t      eq_out_o,
    output logic                        eq_out_stb_o,
    output equalizer_pkg::pilot_sum_t   pilot_sum_o,
    output logic                        pilot_sum_stb_o
);

    // estimator side of the estimate memory
    equalizer_pkg::ram_wr_t est_wr;
    logic [`EQ_ADDR_W-1:0] est_rd_addr;
    equalizer_pkg::iq_t est_rd_data;
    logic est_done;
    // equalizer side
    logic [`EQ_ADDR_W-1:0] eq_rd_addr;
    equalizer_pkg::iq_t eq_rd_data;

    lts_estimator lts_estimator_inst (
        .clock        (clock),
        .reset        (reset),
        .enable_i     (enable_i),
        .sample_i     (sample_i),
        .sample_stb_i (sample_stb_i),
        .rd_data_i    (est_rd_data),
        .wr_o         (est_wr),
        .rd_addr_o    (est_rd_addr),
        .done_o       (est_done)
    );

    channel_ram channel_ram_inst (
        .clock       (clock),
        .wr_i        (est_wr),
        .rd_a_addr_i (est_rd_addr),
        .rd_b_addr_i (eq_rd_addr),
        .rd_a_data_o (est_rd_data),
        .rd_b_data_o (eq_rd_data)
    );

    symbol_equalizer symbol_equalizer_inst (
        .clock           (clock),
        .reset           (reset),
        .enable_i        (enable_i),
        .est_done_i      (est_done),
        .sample_i        (sample_i),
        .sample_stb_i    (sample_stb_i),
        .rd_data_i       (eq_rd_data),
        .rd_addr_o       (eq_rd_addr),
        .eq_out_o        (eq_out_o),
        .eq_out_stb_o    (eq_out_stb_o),
        .pilot_sum_o     (pilot_sum_o),
        .pilot_sum_stb_o (pilot_sum_stb_o)
    );

endmodule

// File: bench/equalizer_tasks.svh
`ifndef EQUALIZER_TASKS_SVH
`define EQUALIZER_TASKS_SVH

    task automatic report_failure(input string msg);
        $display("%s", msg);
        $display("sim failed");
        $fatal(1, "stopped at the first error");
    endtask

    task automatic compare_eq_out(input equalizer_pkg::eq_out_t expected,
                                  input equalizer_pkg::eq_out_t actual, input int due);
        if (actual !== expected) begin
            report_failure($sformatf("error eq_out_o expected %h actual %h", expected, actual));
        end else if (check_timing && due != cycle) begin
            report_failure($sformatf("eq_out_stb_o came in cycle %0d instead of cycle %0d",
                                     cycle, due));
        end
    endtask

    task automatic compare_pilot_sum(input equalizer_pkg::pilot_sum_t expected,
                                     input equalizer_pkg::pilot_sum_t actual, input int due);
        if (actual !== expected) begin
            report_failure($sformatf("error pilot_sum_o expected %h actual %h", expected,
                                     actual));
        end else if (check_timing && due != cycle) begin
            report_failure($sformatf("pilot_sum_stb_o came in cycle %0d instead of cycle %0d",
                                     cycle, due));
        end
    endtask

    // mean of both training symbols, second one sign corrected by the reference
    function automatic equalizer_pkg::iq_t estimate_model(input int k);
        logic signed [16:0] sum_i;
        logic signed [16:0] sum_q;
        equalizer_pkg::iq_t r;
        if (lts_ref[k]) begin
            sum_i = 17'(lts_first[k].i) - 17'(lts_second[k].i);
            sum_q = 17'(lts_first[k].q) - 17'(lts_second[k].q);
        end else begin
            sum_i = 17'(lts_first[k].i) + 17'(lts_second[k].i);
            sum_q = 17'(lts_first[k].q) + 17'(lts_second[k].q);
        end
        r.i = sum_i[16:1];
        r.q = sum_q[16:1];
        return r;
    endfunction

    // x * conj(e) and |e|^2
    function automatic equalizer_pkg::eq_out_t data_model(input equalizer_pkg::iq_t x,
                                                          input equalizer_pkg::iq_t e);
        logic signed [31:0] x_i;
        logic signed [31:0] x_q;
        logic signed [31:0] c_i;
        logic signed [31:0] c_q;
        equalizer_pkg::eq_out_t r;
        x_i = x.i;
        x_q = x.q;
        // conjugate the estimate first, then a plain complex multiply
        c_i = e.i;
        c_q = -32'(e.q);
        r.prod_i = x_i * c_i - x_q * c_q;
        r.prod_q = x_i * c_q + x_q * c_i;
        r.mag_sq = c_i * c_i + c_q * c_q;
        return r;
    endfunction

    // conjugated pilot with its polarity, times the estimate
    function automatic equalizer_pkg::pilot_sum_t pilot_term(input equalizer_pkg::iq_t pil,
                                                             input equalizer_pkg::iq_t e,
                                                             input bit pol);
        logic signed [31:0] c_i;
        logic signed [31:0] c_q;
        logic signed [31:0] e_i;
        logic signed [31:0] e_q;
        equalizer_pkg::pilot_sum_t r;
        c_i = pol ? -32'(pil.i) : 32'(pil.i);
        c_q = pol ? 32'(pil.q) : -32'(pil.q);
        e_i = e.i;
        e_q = e.q;
        r.sum_i = c_i * e_i - c_q * e_q;
        r.sum_q = c_i * e_q + c_q * e_i;
        return r;
    endfunction

    task automatic drive_sample(input equalizer_pkg::iq_t value);
        @(negedge clock);
        sample_i = value;
        sample_stb_i = 1'b1;
    endtask

    task automatic drive_idle(input int cycles);
        repeat (cycles) begin
            @(negedge clock);
            sample_stb_i = 1'b0;
        end
    endtask

    task automatic stall_enable(input int cycles);
        repeat (cycles) begin
            @(negedge clock);
            sample_stb_i = 1'b0;
            enable_i = 1'b0;
        end
        @(negedge clock);
        enable_i = 1'b1;
    endtask

    task automatic reset_dut();
        @(negedge clock);
        reset = 1'b1;
        sample_stb_i = 1'b0;
        repeat (2) @(negedge clock);
        reset = 1'b0;
        sym_count = 0;
    endtask

    task automatic random_symbol(output equalizer_pkg::iq_t smp [`EQ_NUM_SC]);
        for (int k = 0; k < `EQ_NUM_SC; k++) begin
            smp[k] = $urandom;
        end
    endtask

    task automatic send_training();
        for (int k = 0; k < `EQ_NUM_SC; k++) begin
            lts_first[k] = $urandom;
            drive_sample(lts_first[k]);
        end
        for (int k = 0; k < `EQ_NUM_SC; k++) begin
            lts_second[k] = $urandom;
            drive_sample(lts_second[k]);
        end
        // estimator writes the last averages and raises done
        drive_idle(4);
    endtask

    // expected results are queued with their due cycle as each sample goes out
    task automatic send_symbol(input equalizer_pkg::iq_t smp [`EQ_NUM_SC], input bit gaps);
        equalizer_pkg::pilot_sum_t acc;
        equalizer_pkg::pilot_sum_t term;
        equalizer_pkg::iq_t est;
        bit pol;
        acc = '0;
        pol = pol_seq[sym_count % `EQ_POL_LEN];
        for (int k = 0; k < `EQ_NUM_SC; k++) begin
            if (gaps && $urandom_range(3) == 0) begin
                drive_idle($urandom_range(3, 1));
            end
            if (gaps && k % 19 == 10) begin
                stall_enable(3);
            end
            drive_sample(smp[k]);
            est = estimate_model(k);
            if (data_mask[k]) begin
                eq_exp_q.push_back(data_model(smp[k], est));
                eq_due_q.push_back(cycle + 2);
            end
            if (pilot_mask[k]) begin
                // index 21 carries the inverted polarity
                term = pilot_term(smp[k], est, (k == 21) ? !pol : pol);
                acc.sum_i += term.sum_i;
                acc.sum_q += term.sum_q;
            end
            if (k == 57) begin
                pilot_exp_q.push_back(acc);
                pilot_due_q.push_back(cycle + 2);
            end
        end
        sym_count++;
    endtask

    // wait for every queued result, then leave room for any extra strobe
    task automatic drain_outputs(input int expected);
        drive_idle(1);
        while (eq_exp_q.size() != 0 || pilot_exp_q.size() != 0) begin
            drive_idle(1);
        end
        drive_idle(4);
        if (eq_count != expected) begin
            report_failure($sformatf("got %0d equalizer outputs where %0d were expected",
                                     eq_count, expected));
        end
        eq_count = 0;
    endtask

`endif

// File: bench/equalizer_tb.sv
`timescale 1ns/10ps
`include "equalizer_defs.svh"

module equalizer_tb;

    // all tests together take about 820 cycles, so this leaves a wide margin
    localparam int max_cycles = 6000;
    localparam logic [`EQ_NUM_SC-1:0] lts_ref = `EQ_LTS_REF;
    localparam logic [`EQ_NUM_SC-1:0] data_mask = `EQ_DATA_MASK;
    localparam logic [`EQ_NUM_SC-1:0] pilot_mask = `EQ_PILOT_MASK;
    localparam logic [`EQ_POL_LEN-1:0] pol_seq = `EQ_POLARITY;

    logic clock;
    logic reset;
    logic enable_i;
    logic sample_stb_i;
    logic eq_out_stb_o;
    logic pilot_sum_stb_o;
    equalizer_pkg::iq_t sample_i;
    equalizer_pkg::eq_out_t eq_out_o;
    equalizer_pkg::pilot_sum_t pilot_sum_o;

    // training symbols as sent
    equalizer_pkg::iq_t lts_first [`EQ_NUM_SC];
    equalizer_pkg::iq_t lts_second [`EQ_NUM_SC];
    // results still owed by the DUT
    equalizer_pkg::eq_out_t eq_exp_q [$];
    equalizer_pkg::pilot_sum_t pilot_exp_q [$];
    int eq_due_q [$];
    int pilot_due_q [$];
    int cycle;
    int sym_count;
    int eq_count;
    bit check_timing;

    `include "equalizer_tasks.svh"

    equalizer_top equalizer_top_inst (
        .clock           (clock),
        .reset           (reset),
        .enable_i        (enable_i),
        .sample_i        (sample_i),
        .sample_stb_i    (sample_stb_i),
        .eq_out_o        (eq_out_o),
        .eq_out_stb_o    (eq_out_stb_o),
        .pilot_sum_o     (pilot_sum_o),
        .pilot_sum_stb_o (pilot_sum_stb_o)
    );

    always #20 clock = ~clock;

    // outputs are registered, so this edge still sees last cycle's values
    always @(posedge clock) begin
        if (eq_out_stb_o && eq_exp_q.size() == 0) begin
            report_failure("eq_out_stb_o pulsed while no output was expected");
        end else if (eq_out_stb_o) begin
            compare_eq_out(eq_exp_q.pop_front(), eq_out_o, eq_due_q.pop_front());
            eq_count++;
        end
        if (pilot_sum_stb_o && pilot_exp_q.size() == 0) begin
            report_failure("pilot_sum_stb_o pulsed while no pilot sum was expected");
        end else if (pilot_sum_stb_o) begin
            compare_pilot_sum(pilot_exp_q.pop_front(), pilot_sum_o, pilot_due_q.pop_front());
        end
        cycle++;
        if (cycle >= max_cycles) begin
            $display("run did not finish within %0d cycles", max_cycles);
            $display("sim failed");
            $fatal(1, "cycle limit reached");
        end
    end

    task automatic test_quiet_training();
        drive_idle(10);
        send_training();
        drain_outputs(0);
    endtask

    // a unit sample returns the conjugated estimate
    task automatic test_unit_symbol();
        equalizer_pkg::iq_t smp [`EQ_NUM_SC];
        for (int k = 0; k < `EQ_NUM_SC; k++) begin
            smp[k] = '{i: 16'sd1, q: 16'sd0};
        end
        send_symbol(smp, 1'b0);
        drain_outputs(`EQ_NUM_DATA);
    endtask

    task automatic test_random_symbol();
        equalizer_pkg::iq_t smp [`EQ_NUM_SC];
        random_symbol(smp);
        send_symbol(smp, 1'b0);
        drain_outputs(`EQ_NUM_DATA);
    endtask

    // fresh estimate so the symbols use polarity bits 0, 1 and 2
    task automatic test_pilot_sums();
        equalizer_pkg::iq_t smp [`EQ_NUM_SC];
        reset_dut();
        send_training();
        repeat (3) begin
            random_symbol(smp);
            send_symbol(smp, 1'b0);
        end
        drain_outputs(3 * `EQ_NUM_DATA);
    endtask

    // gaps and stalls shift outputs in time but not in value
    task automatic test_gaps_and_stall();
        equalizer_pkg::iq_t smp [`EQ_NUM_SC];
        random_symbol(smp);
        check_timing = 1'b0;
        send_symbol(smp, 1'b1);
        drain_outputs(`EQ_NUM_DATA);
        check_timing = 1'b1;
        send_symbol(smp, 1'b0);
        drain_outputs(`EQ_NUM_DATA);
    endtask

    initial begin
        void'($urandom(56358));
        clock = 1'b0;
        reset = 1'b1;
        enable_i = 1'b1;
        sample_i = '0;
        sample_stb_i = 1'b0;
        cycle = 0;
        sym_count = 0;
        eq_count = 0;
        check_timing = 1'b1;
        reset_dut();
        test_quiet_training();
        test_unit_symbol();
        test_random_symbol();
        test_pilot_sums();
        test_gaps_and_stall();
        $display("sim passed");
        $finish;
    end

endmodule

// File: flist.f
+incdir+verilog
+incdir+bench
verilog/equalizer_pkg.sv
verilog/lts_estimator.sv
verilog/channel_ram.sv
verilog/symbol_equalizer.sv
verilog/equalizer_top.sv
bench/equalizer_tb.sv

// File: run_sim.sh
#!/bin/sh
# build and run the equalizer testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal -f flist.f \
    --top-module equalizer_tb -o equalizer_sim
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

output=$(./obj_dir/equalizer_sim 2>&1)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if echo "$output" | grep -qx "sim passed"; then
    exit 0
fi
exit 1
